// ==== list.f ====
+incdir+include
verilog/snow_pkg.sv
verilog/cell_memory.sv
verilog/diffusion_solver.sv
verilog/column_sweep.sv
verilog/host_regs.sv
verilog/snow_column_top.sv
tests/tb_snow_column.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the snow column testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_snow_column \
	--Mdir obj_dir -o tb_snow_column
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_snow_column > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Testbench passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== include/column_model.svh ====
`ifndef COLUMN_MODEL_SVH
`define COLUMN_MODEL_SVH

// expected contents of every cell
fx_t model_u [NUM_CELLS];
fx_t model_v [NUM_CELLS];
logic model_frozen [NUM_CELLS];

// column as it stood when the sweep began
fx_t model_old_u [NUM_CELLS];
fx_t model_old_v [NUM_CELLS];
logic model_old_frozen [NUM_CELLS];

fx_t model_alpha;
fx_t model_beta;
fx_t model_gamma;
int model_idx;
int model_sweeps;

// outcome of the last model_step
cell_addr_t model_last_index;
logic model_last_frozen;
fx_t model_last_u;
fx_t model_last_v;

// 2.16 product scaled back down to 2.16
function automatic fx_t fixed_product(input fx_t a, input fx_t b);
	logic signed [35:0] product;
	product = a * b;
	return fx_t'(product >>> 16);
endfunction

// restart latches parameters and lays down the seed
function automatic void model_seed(input fx_t alpha, input fx_t beta, input fx_t gamma);
	fx_t s;
	model_alpha = alpha;
	model_beta = beta;
	model_gamma = gamma;
	for (int i = 0; i < NUM_CELLS; i++) begin
		if (i == SEED_CELL) begin
			model_u[i] = '0;
			model_v[i] = FX_ONE + gamma;
		end else if (i == SEED_CELL - 1 || i == SEED_CELL + 1) begin
			model_u[i] = '0;
			model_v[i] = beta + gamma;
		end else begin
			model_u[i] = beta;
			model_v[i] = '0;
		end
		// seed flags follow the s >= 1 rule
		s = model_u[i] + model_v[i];
		model_frozen[i] = (s >= FX_ONE);
	end
	model_idx = 0;
	model_sweeps = 0;
endfunction

// one committed cell per call
function automatic void model_step();
	int i;
	fx_t u_top;
	fx_t u_bottom;
	fx_t vert_sum;
	fx_t side_sum;
	fx_t u_avg;
	fx_t u_delta;
	fx_t u_raw;
	fx_t u_next;
	fx_t v_sum;
	fx_t v_eff;
	fx_t s_new;
	logic below;
	logic above;
	logic hit;
	i = model_idx;
	// snapshot at the start of a sweep
	if (i == 0) begin
		model_old_u = model_u;
		model_old_v = model_v;
		model_old_frozen = model_frozen;
	end
	// outside the column u is beta and never frozen
	if (i == 0) begin
		u_bottom = model_beta;
		below = 1'b0;
	end else begin
		u_bottom = model_old_u[i - 1];
		below = model_old_frozen[i - 1];
	end
	if (i == NUM_CELLS - 1) begin
		u_top = model_beta;
		above = 1'b0;
	end else begin
		u_top = model_old_u[i + 1];
		above = model_old_frozen[i + 1];
	end
	v_sum = model_old_v[i] + model_gamma;
	v_eff = (v_sum >= FX_ONE) ? FX_ONE : v_sum;
	// diffusion update of u
	vert_sum = u_top + u_bottom + model_beta;
	side_sum = model_beta + model_beta + model_beta;
	u_avg = fixed_product(vert_sum, FX_SIXTH) + fixed_product(side_sum, FX_SIXTH);
	u_delta = u_avg - model_old_u[i];
	u_raw = model_old_u[i] + fixed_product(model_alpha >>> 1, u_delta);
	u_next = (u_raw >= FX_ONE) ? FX_ONE : u_raw;
	s_new = u_next + v_eff;
	hit = below || model_old_frozen[i] || above;
	model_frozen[i] = (s_new >= FX_ONE);
	model_u[i] = hit ? '0 : s_new;
	model_v[i] = hit ? s_new : '0;
	model_last_index = cell_addr_t'(i);
	model_last_frozen = model_frozen[i];
	model_last_u = model_u[i];
	model_last_v = model_v[i];
	// wrap after the top cell
	if (i == NUM_CELLS - 1) begin
		model_idx = 0;
		model_sweeps++;
	end else begin
		model_idx++;
	end
endfunction

`endif

// ==== tests/tb_snow_column.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_snow_column
	import snow_pkg::*;
();

	// 10 seed steps plus 3 random sets of 25 plus 4 and 10 around a mid-sweep restart
	localparam int TOTAL_STEPS = 99;
	localparam int CYCLE_LIMIT = 40 * TOTAL_STEPS + 2000;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_wdata;
	wb_data_t wb_rdata;
	logic wb_ack;

	int value_errors;
	int protocol_errors;
	int cycle_count;
	logic prev_ack;

	`include "column_model.svh"

	snow_column_top snow_column_top_inst (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_wdata(wb_wdata),
		.wb_rdata(wb_rdata),
		.wb_ack(wb_ack)
	);

	//////////////////////////////////////////////////
	// clock, timeout, ack monitor
	//////////////////////////////////////////////////

	// 8 ns period
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	// ack is a single cycle pulse
	always @(posedge clk) begin
		#2;
		if (!rst && wb_ack && prev_ack) begin
			$display("ERROR at %0t ns: ack stayed high for two cycles", $time);
			protocol_errors++;
		end
		prev_ack = wb_ack;
	end

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_fx(input fx_t got, input fx_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_index(input cell_addr_t got, input cell_addr_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
			value_errors++;
		end
	endtask

	// raw register words
	task automatic check_word(input wb_data_t got, input wb_data_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_count(input logic [15:0] got, input logic [15:0] exp,
		input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
			value_errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// wishbone master
	//////////////////////////////////////////////////

	task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
		int waited;
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = addr;
		wb_wdata = data;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (wb_ack !== 1'b1);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// ack due on the first edge
		if (waited != 1) begin
			$display("ERROR at %0t ns: write ack came after %0d cycles", $time, waited);
			protocol_errors++;
		end
	endtask

	task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
		int waited;
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = addr;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (wb_ack !== 1'b1);
		// data valid with ack
		data = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		if (waited != 1) begin
			$display("ERROR at %0t ns: read ack came after %0d cycles", $time, waited);
			protocol_errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// column operations
	//////////////////////////////////////////////////

	// parameters go first so the restart latches them
	task automatic restart_column(input fx_t a, input fx_t b, input fx_t g);
		wb_write(REG_ALPHA, {14'd0, a});
		wb_write(REG_BETA, {14'd0, b});
		wb_write(REG_GAMMA, {14'd0, g});
		wb_write(REG_CTRL, 32'd1);
		model_seed(a, b, g);
	endtask

	task automatic run_step();
		wb_data_t word;
		int polls;
		wb_write(REG_STEP, 32'd1);
		wb_read(REG_STEP, word);
		check_flag(word[0], 1'b1, "STEP pending before commit");
		polls = 0;
		while (word[0] === 1'b1 && polls < 16) begin
			wb_read(REG_STEP, word);
			polls++;
		end
		if (word[0] !== 1'b0) begin
			$display("ERROR at %0t ns: step request was never committed", $time);
			protocol_errors++;
		end
		model_step();
		// index, frozen flag, sweep count
		wb_read(REG_CELL, word);
		check_index(word[3:0], model_last_index, "CELL index");
		check_flag(word[8], model_last_frozen, "CELL frozen");
		check_count(word[31:16], model_sweeps[15:0], "CELL sweep count");
		wb_read(REG_LAST_U, word);
		check_fx(word[17:0], model_last_u, "LAST_U");
		check_flag(word[31:18] == {14{word[17]}}, 1'b1, "LAST_U sign extension");
		wb_read(REG_LAST_V, word);
		check_fx(word[17:0], model_last_v, "LAST_V");
		check_flag(word[31:18] == {14{word[17]}}, 1'b1, "LAST_V sign extension");
	endtask

	function automatic fx_t random_fx(input int unsigned limit);
		return fx_t'($urandom % (limit + 1));
	endfunction

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		wb_data_t word;
		fx_t a;
		fx_t b;
		fx_t g;
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdata = '0;
		value_errors = 0;
		protocol_errors = 0;
		cycle_count = 0;
		prev_ack = 1'b0;
		void'($urandom(32'h70ed_0681));
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		// every register reads zero after reset
		for (int r = 0; r < 8; r++) begin
			wb_read(wb_addr_t'(r), word);
			check_word(word, 32'd0, $sformatf("reset value of register %0d", r));
		end
		// parameter readback
		wb_write(REG_ALPHA, 32'h0002_5a5a);
		wb_write(REG_BETA, 32'h0001_0000);
		wb_write(REG_GAMMA, 32'h0000_0123);
		wb_read(REG_ALPHA, word);
		check_word(word, 32'h0002_5a5a, "ALPHA readback");
		wb_read(REG_BETA, word);
		check_word(word, 32'h0001_0000, "BETA readback");
		wb_read(REG_GAMMA, word);
		check_word(word, 32'h0000_0123, "GAMMA readback");

		// first sweep straight from the seed
		restart_column(FX_ONE, fx_t'(18'h0_6666), fx_t'(18'h0_0200));
		for (int s = 0; s < NUM_CELLS; s++) begin
			run_step();
		end

		// random parameters running past the wrap
		for (int p = 0; p < 3; p++) begin
			a = random_fx(32'd65536);
			b = random_fx(32'd65536);
			g = random_fx(32'd1024);
			restart_column(a, b, g);
			for (int s = 0; s < 25; s++) begin
				run_step();
			end
		end

		// restart part way through a sweep
		a = random_fx(32'd65536);
		b = random_fx(32'd65536);
		g = random_fx(32'd1024);
		restart_column(a, b, g);
		for (int s = 0; s < 4; s++) begin
			run_step();
		end
		a = random_fx(32'd65536);
		b = random_fx(32'd65536);
		g = random_fx(32'd1024);
		restart_column(a, b, g);
		run_step();
		// the first commit after a reseed is cell 0 again
		wb_read(REG_CELL, word);
		check_index(word[3:0], 4'd0, "first cell after restart");
		for (int s = 1; s < NUM_CELLS; s++) begin
			run_step();
		end

		$display("summary: %0d value errors, %0d protocol errors", value_errors,
			protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cell_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module cell_memory
	import snow_pkg::*;
(
	input wire clk,
	input wire we,
	input wire cell_addr_t waddr,
	input wire cell_addr_t raddr,
	input wire fx_t wdata,
	output fx_t rdata
);

	// one word per cell
	fx_t mem [NUM_CELLS];

	// write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read, old data on a same-address write
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== verilog/column_sweep.sv ====
`timescale 1ns/100ps
`default_nettype none

module column_sweep
	import snow_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire restart,
	input wire fx_t alpha_in,
	input wire fx_t beta_in,
	input wire fx_t gamma_in,
	input wire step_pending,
	output logic step_done,
	output cell_addr_t mem_raddr,
	output cell_addr_t mem_waddr,
	output logic mem_we,
	output fx_t u_wdata,
	output fx_t v_wdata,
	input wire fx_t u_rdata,
	input wire fx_t v_rdata,
	output fx_t u_top,
	output fx_t u_bottom,
	output fx_t u_self,
	output fx_t v_eff,
	output fx_t alpha,
	output fx_t beta,
	input wire fx_t u_next,
	input wire frozen,
	output cell_addr_t last_index,
	output logic last_frozen,
	output fx_t last_u,
	output fx_t last_v,
	output logic [15:0] sweep_count
);

	sweep_state_t state;
	cell_addr_t cell_idx;
	cell_addr_t top_addr;
	logic is_top;
	logic top_phase;
	fx_t gamma;
	// frozen flags from the previous sweep, one per cell
	logic [NUM_CELLS-1:0] frozen_vec;
	logic frozen_below;
	logic frozen_above;
	logic receptive;
	fx_t seed_u;
	fx_t seed_v;
	fx_t seed_sum;
	fx_t v_sum;
	fx_t s_new;
	fx_t commit_u;
	fx_t commit_v;

	//////////////////////////////////////////////////
	// addressing and neighbor flags
	//////////////////////////////////////////////////

	assign is_top = (cell_idx == cell_addr_t'(NUM_CELLS - 1));
	// no cell above the top one
	assign top_addr = is_top ? cell_idx : cell_idx + 4'd1;
	assign frozen_above = is_top ? 1'b0 : frozen_vec[top_addr];
	// any frozen neighbor makes this cell receptive
	assign receptive = frozen_below | frozen_vec[cell_idx] | frozen_above;

	// self first, then the cell above
	assign mem_raddr = (state == WAIT_READ) ? top_addr : cell_idx;
	assign mem_waddr = cell_idx;
	assign mem_we = (state == SEED) || (state == COMMIT);

	//////////////////////////////////////////////////
	// seed values
	//////////////////////////////////////////////////

	always_comb begin
		if (cell_idx == SEED_CELL) begin
			// the single frozen crystal
			seed_u = '0;
			seed_v = FX_ONE + gamma;
		end else if (cell_idx == SEED_CELL - 4'd1 || cell_idx == SEED_CELL + 4'd1) begin
			// receptive ring around it
			seed_u = '0;
			seed_v = beta + gamma;
		end else begin
			// plain vapor everywhere else
			seed_u = beta;
			seed_v = '0;
		end
	end

	assign seed_sum = seed_u + seed_v;

	//////////////////////////////////////////////////
	// commit values
	//////////////////////////////////////////////////

	// v plus gamma, capped at 1.0
	assign v_sum = v_rdata + gamma;
	assign s_new = u_next + v_eff;

	// receptive cells lock the mass into v
	assign commit_u = receptive ? '0 : s_new;
	assign commit_v = receptive ? s_new : '0;

	assign u_wdata = (state == SEED) ? seed_u : commit_u;
	assign v_wdata = (state == SEED) ? seed_v : commit_v;

	// restart cancels a commit in flight
	assign step_done = (state == COMMIT) && !restart;

	//////////////////////////////////////////////////
	// controller
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SEED;
			cell_idx <= '0;
			top_phase <= 1'b0;
			alpha <= '0;
			beta <= '0;
			gamma <= '0;
			last_index <= '0;
			last_frozen <= 1'b0;
			last_u <= '0;
			last_v <= '0;
			sweep_count <= '0;
		end else if (restart) begin
			// new parameters hold until the next restart
			state <= SEED;
			cell_idx <= '0;
			top_phase <= 1'b0;
			alpha <= alpha_in;
			beta <= beta_in;
			gamma <= gamma_in;
			sweep_count <= '0;
		end else begin
			case (state)
				SEED: begin
					// one cell per cycle, bottom to top
					if (is_top) begin
						cell_idx <= '0;
						state <= IDLE;
					end else begin
						cell_idx <= cell_idx + 4'd1;
					end
				end
				IDLE: begin
					if (step_pending) begin
						state <= FETCH;
					end
				end
				FETCH: begin
					state <= WAIT_READ;
				end
				WAIT_READ: begin
					// two reads back to back
					top_phase <= !top_phase;
					if (top_phase) begin
						state <= SOLVE;
					end
				end
				SOLVE: begin
					// solver frozen flag settles here
					state <= COMMIT;
				end
				COMMIT: begin
					last_index <= cell_idx;
					last_frozen <= frozen;
					last_u <= commit_u;
					last_v <= commit_v;
					if (is_top) begin
						cell_idx <= '0;
						sweep_count <= sweep_count + 16'd1;
					end else begin
						cell_idx <= cell_idx + 4'd1;
					end
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// solver operands and carried state
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == SEED) begin
			frozen_vec[cell_idx] <= (seed_sum >= FX_ONE);
			// bottom boundary for cell 0
			u_bottom <= beta;
			frozen_below <= 1'b0;
		end
		if (state == WAIT_READ && !top_phase) begin
			u_self <= u_rdata;
			v_eff <= (v_sum >= FX_ONE) ? FX_ONE : v_sum;
		end
		if (state == WAIT_READ && top_phase) begin
			u_top <= is_top ? beta : u_rdata;
		end
		if (state == COMMIT) begin
			frozen_vec[cell_idx] <= frozen;
			// old values of this cell become the next cell's bottom
			frozen_below <= is_top ? 1'b0 : frozen_vec[cell_idx];
			u_bottom <= is_top ? beta : u_self;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/diffusion_solver.sv ====
`timescale 1ns/100ps
`default_nettype none

module diffusion_solver
	import snow_pkg::*;
(
	input wire clk,
	input wire fx_t u_top,
	input wire fx_t u_bottom,
	input wire fx_t u_self,
	input wire fx_t v_eff,
	input wire fx_t alpha,
	input wire fx_t beta,
	output fx_t u_next,
	output logic frozen
);

	fx_t vert_sum;
	fx_t side_sum;
	fx_t u_avg;
	fx_t u_delta;
	fx_t u_step;
	fx_t u_raw;
	fx_t s_total;

	//////////////////////////////////////////////////
	// neighbor average
	//////////////////////////////////////////////////

	// top, bottom and the left side cell
	assign vert_sum = u_top + u_bottom + beta;
	// right and both corner cells are boundary
	assign side_sum = beta + beta + beta;
	// split in two groups of three to keep the sums in range
	assign u_avg = fx_mult(vert_sum, FX_SIXTH) + fx_mult(side_sum, FX_SIXTH);

	//////////////////////////////////////////////////
	// diffusion step
	//////////////////////////////////////////////////

	// alpha/2 times (average minus self)
	assign u_delta = u_avg - u_self;
	assign u_step = fx_mult(alpha >>> 1, u_delta);
	assign u_raw = u_self + u_step;

	// saturate at 1.0
	assign u_next = (u_raw >= FX_ONE) ? FX_ONE : u_raw;

	// total mass s = u + v
	assign s_total = u_next + v_eff;

	// frozen once s reaches 1.0
	always_ff @(posedge clk) begin
		frozen <= (s_total >= FX_ONE);
	end

endmodule

`default_nettype wire

// ==== verilog/host_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module host_regs
	import snow_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire wb_addr_t wb_adr,
	input wire wb_data_t wb_wdata,
	output wb_data_t wb_rdata,
	output logic wb_ack,
	output logic restart,
	output fx_t alpha,
	output fx_t beta,
	output fx_t gamma,
	output logic step_pending,
	input wire step_done,
	input wire cell_addr_t last_index,
	input wire last_frozen,
	input wire fx_t last_u,
	input wire fx_t last_v,
	input wire [15:0] sweep_count
);

	logic req;
	logic wr_req;
	logic rd_req;
	wb_data_t read_word;

	// new transfer, held off while ack is up
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr_req = req && wb_we;
	assign rd_req = req && !wb_we;

	//////////////////////////////////////////////////
	// read mux
	//////////////////////////////////////////////////

	always_comb begin
		case (wb_adr)
			// control is a strobe only
			REG_CTRL: read_word = '0;
			REG_ALPHA: read_word = {14'd0, alpha};
			REG_BETA: read_word = {14'd0, beta};
			REG_GAMMA: read_word = {14'd0, gamma};
			REG_STEP: read_word = {31'd0, step_pending};
			// sweep count, frozen flag, index
			REG_CELL: read_word = {sweep_count, 7'd0, last_frozen, 4'd0, last_index};
			REG_LAST_U: read_word = {{14{last_u[17]}}, last_u};
			REG_LAST_V: read_word = {{14{last_v[17]}}, last_v};
			default: read_word = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			wb_rdata <= '0;
			restart <= 1'b0;
			alpha <= '0;
			beta <= '0;
			gamma <= '0;
			step_pending <= 1'b0;
		end else begin
			// single cycle ack, never stalls
			wb_ack <= req;
			// one pulse per CTRL write with bit 0 set
			restart <= wr_req && (wb_adr == REG_CTRL) && wb_wdata[0];

			if (wr_req) begin
				case (wb_adr)
					REG_ALPHA: alpha <= wb_wdata[17:0];
					REG_BETA: beta <= wb_wdata[17:0];
					REG_GAMMA: gamma <= wb_wdata[17:0];
					default: ;
				endcase
			end

			// new request beats a commit in the same cycle
			if (wr_req && (wb_adr == REG_STEP) && wb_wdata[0]) begin
				step_pending <= 1'b1;
			end else if (step_done) begin
				step_pending <= 1'b0;
			end

			// read data lines up with ack
			if (rd_req) begin
				wb_rdata <= read_word;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/snow_column_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module snow_column_top
	import snow_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire wb_addr_t wb_adr,
	input wire wb_data_t wb_wdata,
	output wb_data_t wb_rdata,
	output logic wb_ack
);

	// host to controller
	logic restart;
	logic step_pending;
	logic step_done;
	fx_t param_alpha;
	fx_t param_beta;
	fx_t param_gamma;

	// results back to the host
	cell_addr_t last_index;
	logic last_frozen;
	fx_t last_u;
	fx_t last_v;
	logic [15:0] sweep_count;

	// memory ports, shared address for u and v
	cell_addr_t mem_raddr;
	cell_addr_t mem_waddr;
	logic mem_we;
	fx_t u_wdata;
	fx_t v_wdata;
	fx_t u_rdata;
	fx_t v_rdata;

	// solver operands
	fx_t u_top;
	fx_t u_bottom;
	fx_t u_self;
	fx_t v_eff;
	fx_t solve_alpha;
	fx_t solve_beta;
	fx_t u_next;
	logic frozen;

	//////////////////////////////////////////////////
	// host register block
	//////////////////////////////////////////////////

	host_regs host_regs_inst (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_wdata(wb_wdata),
		.wb_rdata(wb_rdata),
		.wb_ack(wb_ack),
		.restart(restart),
		.alpha(param_alpha),
		.beta(param_beta),
		.gamma(param_gamma),
		.step_pending(step_pending),
		.step_done(step_done),
		.last_index(last_index),
		.last_frozen(last_frozen),
		.last_u(last_u),
		.last_v(last_v),
		.sweep_count(sweep_count)
	);

	//////////////////////////////////////////////////
	// sweep controller
	//////////////////////////////////////////////////

	column_sweep column_sweep_inst (
		.clk(clk),
		.rst(rst),
		.restart(restart),
		.alpha_in(param_alpha),
		.beta_in(param_beta),
		.gamma_in(param_gamma),
		.step_pending(step_pending),
		.step_done(step_done),
		.mem_raddr(mem_raddr),
		.mem_waddr(mem_waddr),
		.mem_we(mem_we),
		.u_wdata(u_wdata),
		.v_wdata(v_wdata),
		.u_rdata(u_rdata),
		.v_rdata(v_rdata),
		.u_top(u_top),
		.u_bottom(u_bottom),
		.u_self(u_self),
		.v_eff(v_eff),
		.alpha(solve_alpha),
		.beta(solve_beta),
		.u_next(u_next),
		.frozen(frozen),
		.last_index(last_index),
		.last_frozen(last_frozen),
		.last_u(last_u),
		.last_v(last_v),
		.sweep_count(sweep_count)
	);

	// one cell at a time
	diffusion_solver diffusion_solver_inst (
		.clk(clk),
		.u_top(u_top),
		.u_bottom(u_bottom),
		.u_self(u_self),
		.v_eff(v_eff),
		.alpha(solve_alpha),
		.beta(solve_beta),
		.u_next(u_next),
		.frozen(frozen)
	);

	//////////////////////////////////////////////////
	// cell storage
	//////////////////////////////////////////////////

	// diffusing mass
	cell_memory u_mem (
		.clk(clk),
		.we(mem_we),
		.waddr(mem_waddr),
		.raddr(mem_raddr),
		.wdata(u_wdata),
		.rdata(u_rdata)
	);

	// locked mass
	cell_memory v_mem (
		.clk(clk),
		.we(mem_we),
		.waddr(mem_waddr),
		.raddr(mem_raddr),
		.wdata(v_wdata),
		.rdata(v_rdata)
	);

endmodule

`default_nettype wire

// ==== verilog/snow_pkg.sv ====
`default_nettype none

package snow_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	// signed 2.16 fixed point, u and v both use it
	typedef logic signed [17:0] fx_t;
	// index of one hexagonal cell
	typedef logic [3:0] cell_addr_t;
	// wishbone word address and data
	typedef logic [2:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// column of ten cells, seed sits in the middle
	localparam int NUM_CELLS = 10;
	localparam cell_addr_t SEED_CELL = 4'd4;

	// 1.0 caps u and v and marks a cell as frozen
	localparam fx_t FX_ONE = 18'sb01_0000000000000000;
	// six neighbors per hexagon
	localparam fx_t FX_SIXTH = 18'sb00_0010101010101010;

	//////////////////////////////////////////////////
	// register map
	//////////////////////////////////////////////////

	localparam wb_addr_t REG_CTRL = 3'd0;
	localparam wb_addr_t REG_ALPHA = 3'd1;
	localparam wb_addr_t REG_BETA = 3'd2;
	localparam wb_addr_t REG_GAMMA = 3'd3;
	localparam wb_addr_t REG_STEP = 3'd4;
	localparam wb_addr_t REG_CELL = 3'd5;
	localparam wb_addr_t REG_LAST_U = 3'd6;
	localparam wb_addr_t REG_LAST_V = 3'd7;

	// sweep controller
	typedef enum logic [2:0] {SEED, IDLE, FETCH, WAIT_READ, SOLVE, COMMIT} sweep_state_t;

	// 2.16 times 2.16 gives 4.32, keep sign and the 2.16 field
	function automatic fx_t fx_mult(input fx_t a, input fx_t b);
		logic signed [35:0] prod;
		prod = a * b;
		return {prod[35], prod[32:16]};
	endfunction

endpackage

`default_nettype wire
